// File: src/bm_cfg_pkg.sv
package bm_cfg_pkg;

	// Transaction ID carried back to the master
	parameter int unsigned TID_W  = 4;

	// Master number, used as the routing tag on slave beats
	parameter int unsigned MID_W  = 4;

	// Slave number, wide enough for 32 slave ports
	parameter int unsigned SID_W  = 5;

	parameter int unsigned DATA_W = 32; // Read data
	parameter int unsigned RESP_W = 2;  // OKAY/EXOKAY/SLVERR/DECERR

	typedef logic [SID_W-1:0] sid_t;

endpackage

// File: src/bm_chan_pkg.sv
package bm_chan_pkg;

	import bm_cfg_pkg::*;

	// Beat as presented by a slave port, still tagged with its master
	typedef struct packed {
		logic [MID_W-1:0]  mid;
		logic [TID_W-1:0]  tid;
		logic [DATA_W-1:0] data;
		logic [RESP_W-1:0] resp;
		logic              last;
	} slv_resp_t;

	// Beat as seen on the master port, master tag removed
	typedef struct packed {
		logic [TID_W-1:0]  tid;
		logic [DATA_W-1:0] data;
		logic [RESP_W-1:0] resp;
		logic              last; // End of burst
	} mst_resp_t;

endpackage

// File: src/resp_order_queue.sv
`timescale 1ns/10ps

module resp_order_queue #(
	parameter int unsigned OUT_DEPTH = 4
) (
	input  logic             aclk,
	input  logic             aresetn,
	input  logic             push,
	input  bm_cfg_pkg::sid_t push_sid,
	input  logic             pop,
	output bm_cfg_pkg::sid_t head_sid,
	output logic             full,
	output logic             idle
);
	import bm_cfg_pkg::*;

	localparam int unsigned PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(OUT_DEPTH + 1);

	sid_t             mem [OUT_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Wrap at OUT_DEPTH so non power of two depths work too
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(OUT_DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	assign do_push = push & ~full;
	assign do_pop  = pop & ~idle;

	assign full     = (count == CNT_W'(OUT_DEPTH));
	assign idle     = (count == '0);
	assign head_sid = mem[rd_ptr]; // Valid only while not idle

	always_ff @(posedge aclk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_sid;
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// Simultaneous push and pop leaves the count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: src/slave_resp_filter.sv
`timescale 1ns/10ps

module slave_resp_filter #(
	parameter int unsigned SLOT      = 0,
	parameter int unsigned MASTER_ID = 2
) (
	input  bm_chan_pkg::slv_resp_t beat_in,
	input  logic                   beat_valid,
	input  logic                   connect,
	input  bm_cfg_pkg::sid_t       head_sid,
	output logic                   sel_valid,
	output bm_chan_pkg::mst_resp_t sel_beat
);
	import bm_cfg_pkg::*;

	logic tag_hit;
	logic head_hit;

	assign tag_hit  = (beat_in.mid == MID_W'(MASTER_ID));
	assign head_hit = (head_sid == SID_W'(SLOT)); // Only the oldest outstanding slave

	assign sel_valid = beat_valid & connect & tag_hit & head_hit;

	// Unselected slots drive zero so the output stage can OR the beats
	always_comb begin
		sel_beat = '0;
		if (sel_valid) begin
			sel_beat.tid  = beat_in.tid;
			sel_beat.data = beat_in.data;
			sel_beat.resp = beat_in.resp;
			sel_beat.last = beat_in.last;
		end
	end

endmodule

// File: src/resp_out_stage.sv
`timescale 1ns/10ps

module resp_out_stage #(
	parameter int unsigned NUM_SLV = 4
) (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic [NUM_SLV-1:0]     sel_valid,
	input  bm_chan_pkg::mst_resp_t sel_beat [NUM_SLV],
	input  logic                   idle,
	input  bm_chan_pkg::mst_resp_t dec_err_resp,
	input  logic                   dec_err_valid,
	output logic                   dec_err_ready,
	output logic                   mst_resp_ready,
	output logic                   pop,
	output bm_chan_pkg::mst_resp_t resp,
	output logic                   resp_valid,
	input  logic                   resp_ready
);
	import bm_chan_pkg::*;

	mst_resp_t merged_beat;
	logic      merged_valid;
	logic      slot_free;
	logic      slv_take;
	logic      dec_take;

	// At most one filter is selected, the one matching the queue head
	always_comb begin
		merged_beat  = '0;
		merged_valid = 1'b0;
		for (int i = 0; i < NUM_SLV; i++) begin
			merged_beat  = mst_resp_t'(merged_beat | sel_beat[i]);
			merged_valid = merged_valid | sel_valid[i];
		end
	end

	// Output register can take a new beat this cycle
	assign slot_free = ~resp_valid | resp_ready;

	// Slaves are served while requests are outstanding, decode errors otherwise
	assign mst_resp_ready = slot_free & ~idle;
	assign dec_err_ready  = slot_free & idle;

	assign slv_take = merged_valid & mst_resp_ready;
	assign dec_take = dec_err_valid & dec_err_ready;

	assign pop = slv_take & merged_beat.last; // Burst done, next slave

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			resp_valid <= 1'b0;
		end else if (slv_take || dec_take) begin
			resp_valid <= 1'b1;
		end else if (resp_ready) begin
			resp_valid <= 1'b0;
		end
	end

	// Held while resp_valid is high and resp_ready is low
	always_ff @(posedge aclk) begin
		if (dec_take) begin
			resp <= dec_err_resp;
		end else if (slv_take) begin
			resp <= merged_beat;
		end
	end

endmodule

// File: src/us_resp_ctrl.sv
`timescale 1ns/10ps

module us_resp_ctrl #(
	parameter int unsigned NUM_SLV   = 4,
	parameter int unsigned OUT_DEPTH = 4,
	parameter int unsigned MASTER_ID = 2
) (
	input  logic                   aclk,
	input  logic                   aresetn,

	// Request side
	input  logic                   outstanding_en,
	input  bm_cfg_pkg::sid_t       outstanding_sid,
	output logic                   outstanding_ready,
	output logic                   outstanding_idle,

	// Slave side
	input  bm_chan_pkg::slv_resp_t slv_resp [NUM_SLV],
	input  logic [NUM_SLV-1:0]     slv_resp_valid,
	input  logic [NUM_SLV-1:0]     slv_connect,
	output logic                   mst_resp_ready,

	// Local decode errors
	input  bm_chan_pkg::mst_resp_t dec_err_resp,
	input  logic                   dec_err_valid,
	output logic                   dec_err_ready,

	// Master side
	output bm_chan_pkg::mst_resp_t resp,
	output logic                   resp_valid,
	input  logic                   resp_ready
);
	import bm_cfg_pkg::*;
	import bm_chan_pkg::*;

	sid_t               head_sid;
	logic               queue_full;
	logic               queue_pop;
	logic [NUM_SLV-1:0] sel_valid;
	mst_resp_t          sel_beat [NUM_SLV];

	assign outstanding_ready = ~queue_full;

	resp_order_queue #(
		.OUT_DEPTH (OUT_DEPTH)
	) u_order_queue (
		.aclk     (aclk),
		.aresetn  (aresetn),
		.push     (outstanding_en),
		.push_sid (outstanding_sid),
		.pop      (queue_pop),
		.head_sid (head_sid),
		.full     (queue_full),
		.idle     (outstanding_idle)
	);

	for (genvar i = 0; i < NUM_SLV; i++) begin : g_filter
		slave_resp_filter #(
			.SLOT      (i),
			.MASTER_ID (MASTER_ID)
		) u_filter (
			.beat_in    (slv_resp[i]),
			.beat_valid (slv_resp_valid[i]),
			.connect    (slv_connect[i]),
			.head_sid   (head_sid),
			.sel_valid  (sel_valid[i]),
			.sel_beat   (sel_beat[i])
		);
	end

	resp_out_stage #(
		.NUM_SLV (NUM_SLV)
	) u_out_stage (
		.aclk           (aclk),
		.aresetn        (aresetn),
		.sel_valid      (sel_valid),
		.sel_beat       (sel_beat),
		.idle           (outstanding_idle),
		.dec_err_resp   (dec_err_resp),
		.dec_err_valid  (dec_err_valid),
		.dec_err_ready  (dec_err_ready),
		.mst_resp_ready (mst_resp_ready),
		.pop            (queue_pop),
		.resp           (resp),
		.resp_valid     (resp_valid),
		.resp_ready     (resp_ready)
	);

endmodule

// File: testbench/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 4
) (
	output logic aclk,
	output logic aresetn
);

	initial begin
		aclk = 1'b0;
		forever #(PERIOD_NS / 2) aclk = ~aclk;
	end

	// Released just after an edge, like the other inputs
	initial begin
		aresetn = 1'b0;
		repeat (RST_CYCLES) @(posedge aclk);
		#2 aresetn = 1'b1;
	end

endmodule

// File: testbench/resp_checker.sv
`timescale 1ns/10ps

module resp_checker (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  bm_chan_pkg::mst_resp_t resp,
	input  logic                   resp_valid,
	input  logic                   resp_ready,
	input  logic                   outstanding_idle,
	input  logic                   dec_err_ready,
	output int                     pending,
	output int                     total_errors,
	output int                     failed_tests
);
	import bm_chan_pkg::*;

	mst_resp_t exp_q [$];
	mst_resp_t exp_beat;
	int        test_errors = 0;
	int        tests_run   = 0;
	int        beats_seen  = 0;

	initial begin
		pending      = 0;
		total_errors = 0;
		failed_tests = 0;
	end

	task automatic note_error();
		test_errors++;
		total_errors++;
	endtask

	task automatic add_expected(input mst_resp_t b);
		exp_q.push_back(b);
		pending = exp_q.size();
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			note_error();
		end
	endtask

	always @(posedge aclk) begin
		if (aresetn) begin
			if (!outstanding_idle && dec_err_ready) begin
				$display("dec_err_ready is high while a request is still outstanding");
				note_error();
			end
			if (resp_valid && resp_ready) begin
				beats_seen++;
				if (exp_q.size() == 0) begin
					$display("Unexpected beat on resp with nothing pending (tid %h data %h)",
						resp.tid, resp.data);
					note_error();
				end else begin
					exp_beat = exp_q.pop_front();
					pending  = exp_q.size();
					if (resp !== exp_beat) begin
						$display("CHECK FAILED resp: got %h expected %h", resp, exp_beat);
						note_error();
					end
				end
			end
		end
	end

	task automatic end_test(input string name);
		tests_run++;
		if (exp_q.size() != 0) begin
			$display("Test %s ended with %0d expected beats never seen", name, exp_q.size());
			note_error();
			exp_q.delete();
			pending = 0;
		end
		if (test_errors == 0) begin
			$display("PASS %s", name);
		end else begin
			$display("FAIL %s: %0d errors", name, test_errors);
			failed_tests++;
		end
		test_errors = 0;
	endtask

	task automatic report_counts();
		$display("%0d tests run, %0d failed, %0d beats checked, %0d errors",
			tests_run, failed_tests, beats_seen, total_errors);
	endtask

endmodule

// File: testbench/resp_ctrl_assert.sv
`timescale 1ns/10ps

module resp_ctrl_assert (
	input logic                   aclk,
	input logic                   aresetn,
	input logic                   resp_valid,
	input logic                   resp_ready,
	input bm_chan_pkg::mst_resp_t resp,
	input logic                   mst_resp_ready,
	input logic                   dec_err_ready,
	input logic                   pop,
	input logic                   idle
);

	int fail_count = 0;

	// Stalled beat must hold
	hold_while_stalled: assert property (@(posedge aclk) disable iff (!aresetn)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp))
		else begin
			$error("resp or resp_valid changed while stalled");
			fail_count++;
		end

	one_source_ready: assert property (@(posedge aclk) disable iff (!aresetn)
		!(mst_resp_ready && dec_err_ready))
		else begin
			$error("mst_resp_ready and dec_err_ready high together");
			fail_count++;
		end

	no_pop_when_idle: assert property (@(posedge aclk) disable iff (!aresetn)
		!(pop && idle))
		else begin
			$error("pop with an empty order queue");
			fail_count++;
		end

endmodule

bind resp_out_stage resp_ctrl_assert u_assert (
	.aclk           (aclk),
	.aresetn        (aresetn),
	.resp_valid     (resp_valid),
	.resp_ready     (resp_ready),
	.resp           (resp),
	.mst_resp_ready (mst_resp_ready),
	.dec_err_ready  (dec_err_ready),
	.pop            (pop),
	.idle           (idle)
);

// File: testbench/tb_us_resp_ctrl.sv
`timescale 1ns/10ps

module tb_us_resp_ctrl;
	import bm_cfg_pkg::*;
	import bm_chan_pkg::*;

	localparam int NUM_SLV      = 4;
	localparam int OUT_DEPTH    = 4;
	localparam int MASTER_ID    = 2;
	localparam int NUM_ROWS     = 5;
	localparam int TIMEOUT      = 40 * NUM_ROWS + 200;
	localparam int STALL_CYCLES = 6; // Cycles a bad beat is shown at the head

	typedef struct packed {
		logic [2:0]                n_push;
		logic [3:0][SID_W-1:0]     push;
		logic [3:0][2:0]           nbeats;
		logic [3:0][MID_W-1:0]     mid;   // Tag shown first
		logic [3:0]                conn;  // Connect shown first
		logic [3:0][TID_W-1:0]     tid;
		logic [3:0][DATA_W-1:0]    seed;
		logic                      dec;
		logic                      rnd;   // Random resp_ready
	} row_t;

	logic               aclk;
	logic               aresetn;
	logic               outstanding_en;
	sid_t               outstanding_sid;
	logic               outstanding_ready;
	logic               outstanding_idle;
	slv_resp_t          slv_resp [NUM_SLV];
	logic [NUM_SLV-1:0] slv_resp_valid;
	logic [NUM_SLV-1:0] slv_connect;
	logic               mst_resp_ready;
	mst_resp_t          dec_err_resp;
	logic               dec_err_valid;
	logic               dec_err_ready;
	mst_resp_t          resp;
	logic               resp_valid;
	logic               resp_ready;

	row_t        rows [NUM_ROWS];
	string       names [NUM_ROWS];
	row_t        cur;
	sid_t        model_q [$]; // Expected head order
	int          left [NUM_SLV];
	int          idx [NUM_SLV];
	int          stall [NUM_SLV];
	logic        start;
	logic [31:0] lcg_state;
	int          cycles = 0;
	int          pending;
	int          total_errors;
	int          failed_tests;

	tb_clk_gen u_clk_gen (
		.aclk    (aclk),
		.aresetn (aresetn)
	);

	us_resp_ctrl #(
		.NUM_SLV   (NUM_SLV),
		.OUT_DEPTH (OUT_DEPTH),
		.MASTER_ID (MASTER_ID)
	) u_us_resp_ctrl (
		.aclk              (aclk),
		.aresetn           (aresetn),
		.outstanding_en    (outstanding_en),
		.outstanding_sid   (outstanding_sid),
		.outstanding_ready (outstanding_ready),
		.outstanding_idle  (outstanding_idle),
		.slv_resp          (slv_resp),
		.slv_resp_valid    (slv_resp_valid),
		.slv_connect       (slv_connect),
		.mst_resp_ready    (mst_resp_ready),
		.dec_err_resp      (dec_err_resp),
		.dec_err_valid     (dec_err_valid),
		.dec_err_ready     (dec_err_ready),
		.resp              (resp),
		.resp_valid        (resp_valid),
		.resp_ready        (resp_ready)
	);

	resp_checker u_checker (
		.aclk             (aclk),
		.aresetn          (aresetn),
		.resp             (resp),
		.resp_valid       (resp_valid),
		.resp_ready       (resp_ready),
		.outstanding_idle (outstanding_idle),
		.dec_err_ready    (dec_err_ready),
		.pending          (pending),
		.total_errors     (total_errors),
		.failed_tests     (failed_tests)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Beat k of slot s has data counting up from the seed and resp set to the slot number
	function automatic mst_resp_t slave_beat(input row_t r, input int s, input int k);
		mst_resp_t b;
		b.tid  = r.tid[s];
		b.data = r.seed[s] + DATA_W'(k);
		b.resp = RESP_W'(s);
		b.last = (k == int'(r.nbeats[s]) - 1);
		return b;
	endfunction

	task automatic wait_cycle();
		@(posedge aclk);
		#2;
	endtask

	task automatic set_push(input int r, input int n, input int p0, input int p1,
		input int p2, input int p3);
		rows[r].n_push  = 3'(n);
		rows[r].push[0] = SID_W'(p0);
		rows[r].push[1] = SID_W'(p1);
		rows[r].push[2] = SID_W'(p2);
		rows[r].push[3] = SID_W'(p3);
	endtask

	task automatic set_slot(input int r, input int s, input int nb, input int mid,
		input logic conn, input int tid, input logic [31:0] seed);
		rows[r].nbeats[s] = 3'(nb);
		rows[r].mid[s]    = MID_W'(mid);
		rows[r].conn[s]   = conn;
		rows[r].tid[s]    = TID_W'(tid);
		rows[r].seed[s]   = seed;
	endtask

	task automatic fill_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			rows[r] = '0;
		end
		names[0] = "in_order";
		set_push(0, 3, 3, 0, 1, 0);
		set_slot(0, 3, 1, 2, 1'b1, 3, 32'h3000_0000);
		set_slot(0, 0, 1, 2, 1'b1, 4, 32'h0000_1000);
		set_slot(0, 1, 1, 2, 1'b1, 5, 32'h1111_0000);
		names[1] = "filtering";
		set_push(1, 2, 1, 2, 0, 0);
		set_slot(1, 1, 1, 5, 1'b1, 6, 32'h1aaa_0000); // Wrong tag first
		set_slot(1, 2, 2, 2, 1'b0, 7, 32'h2bbb_0000); // Disconnected first
		set_slot(1, 0, 1, 7, 1'b1, 8, 32'h0ccc_0000); // Never pushed
		names[2] = "burst";
		set_push(2, 2, 0, 3, 0, 0);
		set_slot(2, 0, 4, 2, 1'b1, 9, 32'h0b00_0000);
		set_slot(2, 3, 2, 2, 1'b1, 10, 32'h3b00_0000);
		names[3] = "decode_error";
		rows[3].dec = 1'b1;
		set_push(3, 1, 1, 0, 0, 0);
		set_slot(3, 1, 2, 2, 1'b1, 11, 32'h1d00_0000);
		names[4] = "back_pressure";
		rows[4].rnd = 1'b1;
		set_push(4, 4, 2, 0, 3, 1);
		set_slot(4, 0, 3, 2, 1'b1, 12, 32'h0e00_0000);
		set_slot(4, 1, 2, 2, 1'b1, 13, 32'h1e00_0000);
		set_slot(4, 2, 3, 2, 1'b1, 14, 32'h2e00_0000);
		set_slot(4, 3, 2, 2, 1'b1, 15, 32'h3e00_0000);
	endtask

	task automatic drive_slot(input int i);
		mst_resp_t b;
		logic      bad;
		logic      at_head;
		if (left[i] > 0) begin
			b       = slave_beat(cur, i, idx[i]);
			bad     = (cur.mid[i] != MID_W'(MASTER_ID)) || !cur.conn[i];
			at_head = (model_q.size() > 0) && (model_q[0] == SID_W'(i));
			slv_resp_valid[i] = 1'b1;
			if (bad && stall[i] < STALL_CYCLES) begin
				if (at_head) begin
					stall[i]++; // Counted only while the slot could be selected
				end
				slv_resp[i] = '{mid: cur.mid[i], tid: b.tid, data: b.data ^ 32'hbad0_0000,
					resp: b.resp, last: b.last};
				slv_connect[i] = cur.conn[i];
			end else begin
				slv_resp[i] = '{mid: MID_W'(MASTER_ID), tid: b.tid, data: b.data,
					resp: b.resp, last: b.last};
				slv_connect[i] = 1'b1;
			end
		end else begin
			slv_resp_valid[i] = 1'b0;
			slv_connect[i]    = 1'b0;
			slv_resp[i]       = '0;
		end
	endtask

	// Slave models and decode-error source sample at the edge and drive 2 ns later
	always @(posedge aclk) begin
		logic [NUM_SLV-1:0] acc;
		logic               dec_acc;
		logic               load;
		for (int i = 0; i < NUM_SLV; i++) begin
			acc[i] = slv_resp_valid[i] && slv_connect[i] && mst_resp_ready &&
				(slv_resp[i].mid == MID_W'(MASTER_ID)) &&
				(model_q.size() > 0) && (model_q[0] == SID_W'(i));
		end
		dec_acc = dec_err_valid && dec_err_ready;
		load    = start;
		#2;
		if (dec_acc) begin
			dec_err_valid = 1'b0;
		end
		for (int i = 0; i < NUM_SLV; i++) begin
			if (load) begin
				left[i]  = int'(cur.nbeats[i]);
				idx[i]   = 0;
				stall[i] = 0;
			end else if (acc[i]) begin
				idx[i]++;
				left[i]--;
				if (left[i] == 0) begin
					void'(model_q.pop_front()); // Last beat pops the head
				end
			end
		end
		if (load) begin
			start = 1'b0;
		end
		for (int i = 0; i < NUM_SLV; i++) begin
			drive_slot(i);
		end
		lcg_state  = lcg_next(lcg_state);
		resp_ready = cur.rnd ? lcg_state[16] : 1'b1;
	end

	task automatic issue_dec(input int r, input int n);
		mst_resp_t b;
		b.tid  = 4'hf;
		b.data = 32'hdec0_0000 + DATA_W'(r * 2 + n);
		b.resp = 2'b11;
		b.last = 1'b1;
		u_checker.add_expected(b);
		dec_err_resp  = b;
		dec_err_valid = 1'b1;
	endtask

	task automatic push_slave(input sid_t s);
		while (!outstanding_ready) begin
			wait_cycle();
		end
		outstanding_en  = 1'b1;
		outstanding_sid = s;
		model_q.push_back(s);
		for (int k = 0; k < int'(cur.nbeats[s]); k++) begin
			u_checker.add_expected(slave_beat(cur, int'(s), k));
		end
		wait_cycle();
		outstanding_en = 1'b0;
	endtask

	task automatic run_row(input int r);
		cur = rows[r];
		if (cur.dec) begin
			issue_dec(r, 0); // Queue still empty here
			while (dec_err_valid) begin
				wait_cycle();
			end
		end
		for (int k = 0; k < int'(cur.n_push); k++) begin
			push_slave(cur.push[k]);
		end
		if (int'(cur.n_push) == OUT_DEPTH) begin
			u_checker.check_value("outstanding_ready", 64'(outstanding_ready), 64'd0);
		end
		if (cur.dec) begin
			issue_dec(r, 1); // Must wait for the queue to drain
		end
		start = 1'b1;
		while (pending != 0 || model_q.size() != 0 || dec_err_valid) begin
			wait_cycle();
		end
		cur.nbeats = '0;
		start = 1'b1;
		wait_cycle();
		wait_cycle();
		u_checker.end_test(names[r]);
	endtask

	always @(posedge aclk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles, %0d beats still pending", cycles, pending);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		outstanding_en  = 1'b0;
		outstanding_sid = '0;
		slv_resp        = '{default: '0};
		slv_resp_valid  = '0;
		slv_connect     = '0;
		dec_err_resp    = '0;
		dec_err_valid   = 1'b0;
		resp_ready      = 1'b1;
		start           = 1'b0;
		cur             = '0;
		lcg_state       = 32'h7e07_ee5c;
		for (int i = 0; i < NUM_SLV; i++) begin
			left[i]  = 0;
			idx[i]   = 0;
			stall[i] = 0;
		end
		fill_table();
		@(posedge aresetn);
		wait_cycle();
		u_checker.check_value("resp_valid", 64'(resp_valid), 64'd0);
		u_checker.check_value("outstanding_idle", 64'(outstanding_idle), 64'd1);
		u_checker.check_value("outstanding_ready", 64'(outstanding_ready), 64'd1);
		u_checker.check_value("mst_resp_ready", 64'(mst_resp_ready), 64'd0);
		u_checker.check_value("dec_err_ready", 64'(dec_err_ready), 64'd1);
		u_checker.end_test("reset_state");
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		u_checker.report_counts();
		if (total_errors == 0 && failed_tests == 0 &&
			u_us_resp_ctrl.u_out_stage.u_assert.fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: compile.f
src/bm_cfg_pkg.sv
src/bm_chan_pkg.sv
src/resp_order_queue.sv
src/slave_resp_filter.sv
src/resp_out_stage.sv
src/us_resp_ctrl.sv
testbench/tb_clk_gen.sv
testbench/resp_checker.sv
testbench/resp_ctrl_assert.sv
testbench/tb_us_resp_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_us_resp_ctrl
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
